// ==== design/calcPkg.sv ====
`default_nettype none

package calcPkg;

    // stack words and operands are plain unsigned 32-bit values
    typedef logic [31:0] wordT;

    // host opcode byte
    typedef enum logic [7:0] {
        PUSH  = 8'h01,
        POP   = 8'h02,
        COPY  = 8'h03,
        ADD   = 8'h04,
        SUB   = 8'h05,
        MUL   = 8'h06,
        SWAP  = 8'h09,
        CLEAR = 8'h80
    } opcodeT;

    localparam int FrameBytes = 5;  // opcode then operand, msb first
    localparam int ReplyBytes = 4;  // new top of stack, msb first

endpackage

`default_nettype wire

// ==== design/uartPkg.sv ====
`default_nettype none

package uartPkg;

    localparam int DataBits = 8;  // one start bit and one stop bit around these

    typedef logic [DataBits-1:0] byteT;

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} uartStateT;

endpackage

`default_nettype wire

// ==== design/stackIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface stackIf import calcPkg::*; #(
    parameter int StackAddrBits = 3
);

    opcodeT                 op;
    wordT                   operand;
    logic                   start;    // one-cycle request
    logic                   done;     // one cycle after start
    wordT                   top;      // zero on an empty stack
    logic [StackAddrBits:0] depth;
    logic                   fail;     // held until the next done

    modport ctrl (
        output op, operand, start,
        input  done, top
    );

    modport core (
        input  op, operand, start,
        output done, top, depth, fail
    );

endinterface

`default_nettype wire

// ==== design/uartRx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartRx import uartPkg::*; #(
    parameter int ClksPerBit = 16
) (
    input  logic Clk,
    input  logic arstN,
    input  logic RxLine,
    output byteT rxData,
    output logic rxValid
);

    localparam int CntBits = $clog2(ClksPerBit);
    localparam logic [CntBits-1:0] HalfBit = CntBits'(ClksPerBit / 2 - 1);
    localparam logic [CntBits-1:0] FullBit = CntBits'(ClksPerBit - 1);

    uartStateT          state;
    logic [CntBits-1:0] clkCnt;
    logic [2:0]         bitIdx;
    logic [1:0]         lineSync;
    logic               lineIn;

    assign lineIn = lineSync[1];

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
            lineSync <= 2'b11;  // idle line is high
        else
            lineSync <= {lineSync[0], RxLine};
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state   <= IDLE;
            clkCnt  <= '0;
            bitIdx  <= '0;
            rxValid <= 1'b0;
        end
        else
        begin
            rxValid <= 1'b0;
            clkCnt  <= clkCnt + 1'b1;
            case (state)
                IDLE:
                begin
                    clkCnt <= '0;
                    if (!lineIn)
                        state <= START;
                end
                START:
                begin
                    if (clkCnt == HalfBit)
                    begin
                        clkCnt <= '0;
                        bitIdx <= '0;
                        state  <= lineIn ? IDLE : DATA;  // a short glitch is not a start bit
                    end
                end
                DATA:
                begin
                    if (clkCnt == FullBit)
                    begin
                        clkCnt <= '0;
                        bitIdx <= bitIdx + 1'b1;
                        if (bitIdx == 3'(DataBits - 1))
                            state <= STOP;
                    end
                end
                STOP:
                begin
                    if (clkCnt == FullBit)
                    begin
                        rxValid <= lineIn;  // framing error drops the byte
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        if (state == DATA && clkCnt == FullBit)
            rxData <= {lineIn, rxData[7:1]};  // lsb arrives first
    end

endmodule

`default_nettype wire

// ==== design/uartTx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartTx import uartPkg::*; #(
    parameter int ClksPerBit = 16
) (
    input  logic Clk,
    input  logic arstN,
    input  byteT txData,
    input  logic txStart,
    output logic TxLine,
    output logic txBusy
);

    localparam int CntBits = $clog2(ClksPerBit);
    localparam logic [CntBits-1:0] FullBit = CntBits'(ClksPerBit - 1);

    uartStateT          state;
    logic [CntBits-1:0] clkCnt;
    logic [2:0]         bitIdx;
    byteT               shiftReg;

    assign txBusy = (state != IDLE);
    assign TxLine = (state == START) ? 1'b0 : (state == DATA) ? shiftReg[0] : 1'b1;

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state  <= IDLE;
            clkCnt <= '0;
            bitIdx <= '0;
        end
        else
        begin
            clkCnt <= clkCnt + 1'b1;
            case (state)
                IDLE:
                begin
                    clkCnt <= '0;
                    bitIdx <= '0;
                    if (txStart)
                        state <= START;
                end
                START:
                begin
                    if (clkCnt == FullBit)
                    begin
                        clkCnt <= '0;
                        state  <= DATA;
                    end
                end
                DATA:
                begin
                    if (clkCnt == FullBit)
                    begin
                        clkCnt <= '0;
                        bitIdx <= bitIdx + 1'b1;
                        if (bitIdx == 3'(DataBits - 1))
                            state <= STOP;
                    end
                end
                STOP:
                begin
                    if (clkCnt == FullBit)
                        state <= IDLE;  // busy drops after exactly ten bit times
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        if (state == IDLE && txStart)
            shiftReg <= txData;
        else if (state == DATA && clkCnt == FullBit)
            shiftReg <= shiftReg >> 1;
    end

endmodule

`default_nettype wire

// ==== design/stackCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module stackCore import calcPkg::*; #(
    parameter int StackAddrBits = 3
) (
    input  logic Clk,
    input  logic arstN,
    stackIf.core stk
);

    localparam int Capacity = 1 << StackAddrBits;
    localparam logic [StackAddrBits:0] DepthFull = (StackAddrBits + 1)'(Capacity);

    wordT                   mem [Capacity];
    logic [StackAddrBits-1:0] pushIdx;
    logic [StackAddrBits-1:0] topIdx;
    logic [StackAddrBits-1:0] secIdx;
    wordT                   topWord;
    wordT                   secWord;
    logic                   empty;
    logic                   full;
    logic                   twoUp;
    logic                   legal;
    logic [StackAddrBits:0] nextDepth;

    assign pushIdx = stk.depth[StackAddrBits-1:0];  // wraps to 0 when full, never written then
    assign topIdx  = pushIdx - 1'b1;
    assign secIdx  = pushIdx - 2'd2;
    assign topWord = mem[topIdx];
    assign secWord = mem[secIdx];
    assign empty   = (stk.depth == '0);
    assign full    = (stk.depth == DepthFull);
    assign twoUp   = (stk.depth > (StackAddrBits + 1)'(1));
    assign stk.top = empty ? '0 : topWord;

    always_comb
    begin
        legal     = 1'b0;
        nextDepth = stk.depth;
        case (stk.op)
            PUSH:
            begin
                legal     = !full;
                nextDepth = stk.depth + 1'b1;
            end
            POP:
            begin
                legal     = !empty;
                nextDepth = stk.depth - 1'b1;
            end
            COPY:
            begin
                legal     = !empty && !full;
                nextDepth = stk.depth + 1'b1;
            end
            ADD, SUB, MUL:
            begin
                legal     = twoUp;
                nextDepth = stk.depth - 1'b1;
            end
            SWAP: legal = twoUp;
            CLEAR:
            begin
                legal     = 1'b1;
                nextDepth = '0;
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            stk.depth <= '0;
            stk.done  <= 1'b0;
            stk.fail  <= 1'b0;
        end
        else
        begin
            stk.done <= stk.start;
            if (stk.start)
            begin
                stk.fail <= !legal;
                if (legal)
                    stk.depth <= nextDepth;
            end
        end
    end

    always_ff @(posedge Clk)
    begin
        if (stk.start && legal)
        begin
            case (stk.op)
                PUSH: mem[pushIdx] <= stk.operand;
                COPY: mem[pushIdx] <= topWord;
                ADD:  mem[secIdx] <= secWord + topWord;  // result lands in the second slot
                SUB:  mem[secIdx] <= secWord - topWord;
                MUL:  mem[secIdx] <= secWord * topWord;
                SWAP:
                begin
                    mem[secIdx] <= topWord;
                    mem[topIdx] <= secWord;
                end
                default: ;  // pop and clear only move the depth
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/calcControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module calcControl import calcPkg::*, uartPkg::*;
(
    input  logic Clk,
    input  logic arstN,
    input  byteT rxData,
    input  logic rxValid,
    output byteT txData,
    output logic txStart,
    input  logic txBusy,
    stackIf.ctrl stk,
    output logic Ready
);

    typedef enum logic [1:0] {COLLECT, EXECUTE, WAITCORE, REPLY} ctrlStateT;

    localparam int ByteCntBits  = $clog2(FrameBytes);
    localparam int ReplyCntBits = $clog2(ReplyBytes + 1);

    ctrlStateT               state;
    logic [ByteCntBits-1:0]  byteCnt;
    logic [ReplyCntBits-1:0] replyCnt;
    opcodeT                  opReg;
    wordT                    operandReg;
    wordT                    replyWord;
    wordT                    txWord;
    logic                    replyDone;

    assign replyDone = (replyCnt == ReplyCntBits'(ReplyBytes));
    assign Ready     = (state == COLLECT) && (byteCnt == '0);

    assign stk.start   = (state == EXECUTE);
    assign stk.op      = opReg;
    assign stk.operand = operandReg;

    // the first reply byte leaves straight from the core result
    assign txWord  = (state == WAITCORE) ? stk.top : replyWord;
    assign txData  = txWord[31:24];
    assign txStart = ((state == WAITCORE) && stk.done) ||
                     ((state == REPLY) && !txBusy && !replyDone);

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state    <= COLLECT;
            byteCnt  <= '0;
            replyCnt <= '0;
        end
        else
        begin
            case (state)
                COLLECT:
                begin
                    if (rxValid)
                    begin
                        if (byteCnt == ByteCntBits'(FrameBytes - 1))
                        begin
                            byteCnt <= '0;
                            state   <= EXECUTE;
                        end
                        else
                            byteCnt <= byteCnt + 1'b1;
                    end
                end
                EXECUTE: state <= WAITCORE;
                WAITCORE:
                begin
                    if (stk.done)
                    begin
                        replyCnt <= ReplyCntBits'(1);
                        state    <= REPLY;
                    end
                end
                REPLY:
                begin
                    if (txStart)
                        replyCnt <= replyCnt + 1'b1;
                    else if (!txBusy && replyDone)
                    begin
                        replyCnt <= '0;
                        state    <= COLLECT;  // last byte fully on the line
                    end
                end
                default: state <= COLLECT;
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        if (state == COLLECT && rxValid)
        begin
            if (byteCnt == '0)
                opReg <= opcodeT'(rxData);  // carried as is, the core decodes it
            else
                operandReg <= {operandReg[23:0], rxData};
        end
        if (txStart)
            replyWord <= {txWord[23:0], 8'h00};
    end

endmodule

`default_nettype wire

// ==== design/calcTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module calcTop import uartPkg::*; #(
    parameter int ClksPerBit    = 16,
    parameter int StackAddrBits = 3
) (
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   RxLine,
    output logic                   TxLine,
    output logic                   Ready,
    output logic [StackAddrBits:0] StackDepth,
    output logic                   Error
);

    byteT rxData;
    logic rxValid;
    byteT txData;
    logic txStart;
    logic txBusy;

    stackIf #(.StackAddrBits(StackAddrBits)) stk ();

    assign StackDepth = stk.depth;
    assign Error      = stk.fail;

    uartRx #(.ClksPerBit(ClksPerBit)) rxUnit (
        .Clk     (Clk),
        .arstN   (arstN),
        .RxLine  (RxLine),
        .rxData  (rxData),
        .rxValid (rxValid)
    );

    uartTx #(.ClksPerBit(ClksPerBit)) txUnit (
        .Clk     (Clk),
        .arstN   (arstN),
        .txData  (txData),
        .txStart (txStart),
        .TxLine  (TxLine),
        .txBusy  (txBusy)
    );

    calcControl ctrlUnit (
        .Clk     (Clk),
        .arstN   (arstN),
        .rxData  (rxData),
        .rxValid (rxValid),
        .txData  (txData),
        .txStart (txStart),
        .txBusy  (txBusy),
        .stk     (stk.ctrl),
        .Ready   (Ready)
    );

    stackCore #(.StackAddrBits(StackAddrBits)) stackUnit (
        .Clk   (Clk),
        .arstN (arstN),
        .stk   (stk.core)
    );

endmodule

`default_nettype wire

// ==== verif/calcTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module calcTb import calcPkg::*;;

    localparam int ClksPerBit    = 16;
    localparam int StackAddrBits = 3;
    localparam int Capacity      = 1 << StackAddrBits;
    localparam int MaxCycles     = 60000;  // about 31 commands of about 1500 cycles each

    logic                   Clk = 1'b0;
    logic                   arstN;
    logic                   rxLine;
    logic                   txLine;
    logic                   ready;
    logic [StackAddrBits:0] stackDepth;
    logic                   error;

    logic [31:0] model [Capacity];  // reference stack, bottom at index 0
    int          modelDepth;
    logic [31:0] rngState;
    int          cycleCount;

    calcTop #(.ClksPerBit(ClksPerBit), .StackAddrBits(StackAddrBits)) uut (
        .Clk        (Clk),
        .arstN      (arstN),
        .RxLine     (rxLine),
        .TxLine     (txLine),
        .Ready      (ready),
        .StackDepth (stackDepth),
        .Error      (error)
    );

    initial
    begin
        forever #50 Clk = ~Clk;
    end

    task automatic failRun();
        $display("Testbench failed");
        $fatal(1);
    endtask

    always @(posedge Clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles)
        begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycleCount);
            failRun();
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("ERR %0d ns: %s = %h, expected %h", $time, name, got, exp);
            failRun();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] randWord();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic logic [31:0] modelTop();
        return (modelDepth == 0) ? 32'h0 : model[modelDepth-1];
    endfunction

    // applies one command to the reference stack and tells whether it must fail
    task automatic applyModel(input logic [7:0] op, input logic [31:0] operand,
                              output logic failed);
        logic [31:0] sec;
        logic [31:0] tp;
        failed = 1'b0;
        case (op)
            PUSH:
                if (modelDepth < Capacity)
                begin
                    model[modelDepth] = operand;
                    modelDepth++;
                end
                else
                    failed = 1'b1;
            POP:
                if (modelDepth >= 1)
                    modelDepth--;
                else
                    failed = 1'b1;
            COPY:
                if (modelDepth >= 1 && modelDepth < Capacity)
                begin
                    model[modelDepth] = model[modelDepth-1];
                    modelDepth++;
                end
                else
                    failed = 1'b1;
            ADD, SUB, MUL, SWAP:
                if (modelDepth >= 2)
                begin
                    sec = model[modelDepth-2];
                    tp  = model[modelDepth-1];
                    if (op == SWAP)
                    begin
                        model[modelDepth-2] = tp;
                        model[modelDepth-1] = sec;
                    end
                    else
                    begin
                        if (op == ADD)
                            model[modelDepth-2] = sec + tp;
                        else if (op == SUB)
                            model[modelDepth-2] = sec - tp;  // wraps below zero
                        else
                            model[modelDepth-2] = sec * tp;
                        modelDepth--;
                    end
                end
                else
                    failed = 1'b1;
            CLEAR: modelDepth = 0;
            default: failed = 1'b1;
        endcase
    endtask

    // one serial frame, lsb first, called on a falling edge
    task automatic sendByte(input logic [7:0] b);
        rxLine = 1'b0;
        repeat (ClksPerBit) @(negedge Clk);
        for (int i = 0; i < 8; i++)
        begin
            rxLine = b[i];
            repeat (ClksPerBit) @(negedge Clk);
        end
        rxLine = 1'b1;
        repeat (ClksPerBit) @(negedge Clk);
    endtask

    // returns at the middle of the stop bit
    task automatic getByte(output logic [7:0] b);
        while (txLine !== 1'b0)
            @(negedge Clk);
        repeat (ClksPerBit / 2 - 1) @(negedge Clk);
        assert (txLine === 1'b0)
        else
        begin
            $display("start bit on TxLine did not stay low at %0d ns", $time);
            failRun();
        end
        for (int i = 0; i < 8; i++)
        begin
            repeat (ClksPerBit) @(negedge Clk);
            b[i] = txLine;
        end
        repeat (ClksPerBit) @(negedge Clk);
        assert (txLine === 1'b1)
        else
        begin
            $display("stop bit on TxLine was low at %0d ns", $time);
            failRun();
        end
    endtask

    task automatic runCmd(input logic [7:0] op, input logic [31:0] operand);
        logic [31:0] reply;
        logic [7:0]  b;
        logic        expFail;
        fork
            begin
                sendByte(op);
                for (int k = 3; k >= 0; k--)
                    sendByte(operand[8*k +: 8]);  // operand goes msb first
            end
            begin
                for (int k = 0; k < 4; k++)
                begin
                    getByte(b);
                    reply = {reply[23:0], b};
                    checkValue("Ready", 32'(ready), 32'd0);
                end
            end
        join
        while (ready !== 1'b1)
            @(negedge Clk);
        applyModel(op, operand, expFail);
        checkValue("reply", reply, modelTop());
        checkValue("StackDepth", 32'(stackDepth), 32'(modelDepth));
        checkValue("Error", 32'(error), 32'(expFail));
    endtask

    task automatic testAfterReset();
        checkValue("Ready", 32'(ready), 32'd1);
        checkValue("StackDepth", 32'(stackDepth), 32'd0);
        checkValue("Error", 32'(error), 32'd0);
        checkValue("TxLine", 32'(txLine), 32'd1);
        runCmd(PUSH, randWord());
    endtask

    task automatic testArithmetic();
        runCmd(PUSH, randWord());
        runCmd(ADD, 32'h0);
        runCmd(PUSH, randWord() & 32'h0000_ffff);
        runCmd(PUSH, randWord() | 32'h8000_0000);  // larger than the entry below it
        runCmd(SUB, 32'h0);
        runCmd(PUSH, randWord());
        runCmd(MUL, 32'h0);
    endtask

    task automatic testCopySwapPop();
        runCmd(COPY, randWord());  // operand is ignored
        runCmd(PUSH, randWord());
        runCmd(SWAP, 32'h0);
        repeat (4) runCmd(POP, 32'h0);
    endtask

    task automatic testErrors();
        runCmd(POP, 32'h0);
        runCmd(PUSH, randWord());
        runCmd(ADD, 32'h0);
        runCmd(8'h07, randWord());
        runCmd(PUSH, randWord());
    endtask

    task automatic testOverflowClear();
        runCmd(CLEAR, 32'h0);
        repeat (Capacity + 1) runCmd(PUSH, randWord());  // the last one does not fit
        runCmd(CLEAR, 32'h0);
    endtask

    initial
    begin
        arstN      = 1'b0;
        rxLine     = 1'b1;
        rngState   = 32'd8034;
        modelDepth = 0;
        cycleCount = 0;
        repeat (3) @(negedge Clk);
        arstN = 1'b1;
        @(negedge Clk);
        testAfterReset();
        testArithmetic();
        testCopySwapPop();
        testErrors();
        testOverflowClear();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/calcPkg.sv
design/uartPkg.sv
design/stackIf.sv
design/uartRx.sv
design/uartTx.sv
design/stackCore.sv
design/calcControl.sv
design/calcTop.sv
verif/calcTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the calculator testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module calcTb -o calcSim

./obj_dir/calcSim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
echo "simulation finished without failures"
